//--- exp_top.f
+incdir+rtl
rtl/exp_pkg.sv
rtl/exp_if.sv
rtl/exp_classify.sv
rtl/exp_range_reduce.sv
rtl/exp_assemble.sv
rtl/exp_ctrl.sv
rtl/exp_top.sv
tb/exp_tb.sv

//--- rtl/exp_assemble.sv
`timescale 1ns/1ps
`include "exp_cfg.svh"

module exp_assemble
(
    input  logic                clk,
    input  logic                rst,
    exp_reduce_if.assemble      red,
    output exp_pkg::bf16_t      result_o,
    output logic                result_valid_o
);

    logic signed [9:0]      biased;     // result exponent before saturation
    exp_pkg::man_field_t    man_d;
    exp_pkg::bf16_t         word_d;

    // round(128 * 2^(k/64)) - 128
    function automatic exp_pkg::man_field_t man_lut(input exp_pkg::frac_idx_t k);
        case (k)
            6'd1:    man_lut = 7'd1;
            6'd2:    man_lut = 7'd3;
            6'd3:    man_lut = 7'd4;
            6'd4:    man_lut = 7'd6;
            6'd5:    man_lut = 7'd7;
            6'd6:    man_lut = 7'd9;
            6'd7:    man_lut = 7'd10;
            6'd8:    man_lut = 7'd12;
            6'd9:    man_lut = 7'd13;
            6'd10:   man_lut = 7'd15;
            6'd11:   man_lut = 7'd16;
            6'd12:   man_lut = 7'd18;
            6'd13:   man_lut = 7'd19;
            6'd14:   man_lut = 7'd21;
            6'd15:   man_lut = 7'd23;
            6'd16:   man_lut = 7'd24;   // 2^(1/4)
            6'd17:   man_lut = 7'd26;
            6'd18:   man_lut = 7'd28;
            6'd19:   man_lut = 7'd29;
            6'd20:   man_lut = 7'd31;
            6'd21:   man_lut = 7'd33;
            6'd22:   man_lut = 7'd34;
            6'd23:   man_lut = 7'd36;
            6'd24:   man_lut = 7'd38;
            6'd25:   man_lut = 7'd40;
            6'd26:   man_lut = 7'd42;
            6'd27:   man_lut = 7'd43;
            6'd28:   man_lut = 7'd45;
            6'd29:   man_lut = 7'd47;
            6'd30:   man_lut = 7'd49;
            6'd31:   man_lut = 7'd51;
            6'd32:   man_lut = 7'd53;   // sqrt(2)
            6'd33:   man_lut = 7'd55;
            6'd34:   man_lut = 7'd57;
            6'd35:   man_lut = 7'd59;
            6'd36:   man_lut = 7'd61;
            6'd37:   man_lut = 7'd63;
            6'd38:   man_lut = 7'd65;
            6'd39:   man_lut = 7'd67;
            6'd40:   man_lut = 7'd69;
            6'd41:   man_lut = 7'd72;
            6'd42:   man_lut = 7'd74;
            6'd43:   man_lut = 7'd76;
            6'd44:   man_lut = 7'd78;
            6'd45:   man_lut = 7'd80;
            6'd46:   man_lut = 7'd83;
            6'd47:   man_lut = 7'd85;
            6'd48:   man_lut = 7'd87;   // 2^(3/4)
            6'd49:   man_lut = 7'd90;
            6'd50:   man_lut = 7'd92;
            6'd51:   man_lut = 7'd94;
            6'd52:   man_lut = 7'd97;
            6'd53:   man_lut = 7'd99;
            6'd54:   man_lut = 7'd102;
            6'd55:   man_lut = 7'd104;
            6'd56:   man_lut = 7'd107;
            6'd57:   man_lut = 7'd109;
            6'd58:   man_lut = 7'd112;
            6'd59:   man_lut = 7'd115;
            6'd60:   man_lut = 7'd117;
            6'd61:   man_lut = 7'd120;
            6'd62:   man_lut = 7'd123;
            6'd63:   man_lut = 7'd125;
            default: man_lut = 7'd0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // exponent assembly with saturation
    ////////////////////////////////////////////////////////////
    assign man_d  = red.zero_frac ? '0 : man_lut(red.frac_idx);    // exact power of two
    assign biased = 10'(`EXP_BIAS) + 10'(red.pow_int);

    always_comb
    begin
        if (biased >= 10'sd255)
            word_d = `EXP_PINF;                 // overflow
        else if (biased <= 10'sd0)
            word_d = `EXP_ZERO;                 // denormals flushed too
        else
            word_d = {1'b0, biased[7:0], man_d};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            result_valid_o <= 1'b0;
        else
            result_valid_o <= red.valid;
    end

    always_ff @(posedge clk)
    begin
        if (red.valid)
            result_o <= word_d;
    end

    // one item in flight so each result follows a single valid pulse
    a_valid_follows: assert property (@(posedge clk) disable iff (rst)
        result_valid_o |-> !red.valid);

endmodule

//--- rtl/exp_cfg.svh
`ifndef EXP_CFG_SVH
`define EXP_CFG_SVH

// exponent bias of bfloat16
`define EXP_BIAS 127

// smallest input exponent that can reach the computed path
`define EXP_FIX_BASE_EXP 118

// log2(e) as unsigned q1.15
`define EXP_LOG2E_Q15 47274

// width of the 2^(k/64) table index
`define EXP_FRAC_BITS 6

////////////////////////////////////////////////////////////
// clamping thresholds, magnitudes without the sign bit
////////////////////////////////////////////////////////////
`define EXP_MIN_POS     16'h3B80
`define EXP_MAX_POS     16'h42B2
`define EXP_MIN_NEG_MAG 16'h3B01
`define EXP_MAX_NEG_MAG 16'h42BA

////////////////////////////////////////////////////////////
// direct results
////////////////////////////////////////////////////////////
`define EXP_ONE  16'h3F80
`define EXP_PINF 16'h7F80
`define EXP_ZERO 16'h0000
`define EXP_QNAN 16'h7FC0

`endif

//--- rtl/exp_classify.sv
`timescale 1ns/1ps
`include "exp_cfg.svh"

module exp_classify
(
    exp_check_if.classify check
);

    logic                   op_sign;
    exp_pkg::exp_field_t    op_exp;
    exp_pkg::man_field_t    op_man;
    logic [15:0]            op_mag;     // magnitude, zero extended for the compares

    logic is_nan;
    logic is_inf;
    logic is_zero_dn;
    logic below_min;
    logic above_max;

    assign op_sign = check.operand[15];
    assign op_exp  = check.operand[14:7];
    assign op_man  = check.operand[6:0];
    assign op_mag  = {1'b0, check.operand[14:0]};

    ////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////
    assign is_nan     = (op_exp == 8'hFF) && (op_man != '0);
    assign is_inf     = (op_exp == 8'hFF) && (op_man == '0);
    assign is_zero_dn = (op_exp == '0);     // zero or denormal

    // thresholds differ per sign
    assign below_min = op_sign ? (op_mag < `EXP_MIN_NEG_MAG) : (op_mag < `EXP_MIN_POS);
    assign above_max = op_sign ? (op_mag > `EXP_MAX_NEG_MAG) : (op_mag > `EXP_MAX_POS);

    ////////////////////////////////////////////////////////////
    // direct result select
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        check.is_special     = 1'b1;
        check.special_result = `EXP_ONE;
        if (is_nan)
            check.special_result = `EXP_QNAN;   // canonical quiet nan
        else if (is_inf)
            check.special_result = op_sign ? `EXP_ZERO : `EXP_PINF;
        else if (is_zero_dn || below_min)
            check.special_result = `EXP_ONE;
        else if (above_max)
            check.special_result = op_sign ? `EXP_ZERO : `EXP_PINF;
        else
            check.is_special = 1'b0;            // goes through the table path
    end

    // -inf lands here as well
    assign check.is_clamp_neg_huge = op_sign && !is_nan && (op_mag > `EXP_MAX_NEG_MAG);

endmodule

//--- rtl/exp_ctrl.sv
`timescale 1ns/1ps
`include "exp_cfg.svh"

module exp_ctrl
(
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_i,
    input  exp_pkg::bf16_t  data_i,
    input  logic            padv_i,
    output logic            ready_o,
    output logic            valid_o,
    output exp_pkg::bf16_t  data_o,
    exp_check_if.ctrl       check,
    output logic            start_o,
    output exp_pkg::bf16_t  operand_o,
    input  exp_pkg::bf16_t  result_i,
    input  logic            result_valid_i
);

    exp_pkg::exp_state_t    state;
    exp_pkg::bf16_t         operand_q;
    logic                   accept;

    assign ready_o       = (state == exp_pkg::ST_IDLE);
    assign accept        = valid_i && ready_o;
    assign check.operand = operand_q;
    assign operand_o     = operand_q;
    assign start_o       = (state == exp_pkg::ST_CHECK) && !check.is_special;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= exp_pkg::ST_IDLE;
            valid_o <= 1'b0;
        end
        else
        begin
            case (state)
                exp_pkg::ST_IDLE:
                    if (accept)
                        state <= exp_pkg::ST_CHECK;
                exp_pkg::ST_CHECK:
                begin
                    if (check.is_special)
                    begin
                        state   <= exp_pkg::ST_DONE;
                        valid_o <= 1'b1;
                    end
                    else
                        state <= exp_pkg::ST_WAIT;  // start_o fires this cycle
                end
                exp_pkg::ST_WAIT:
                    if (result_valid_i)
                    begin
                        state   <= exp_pkg::ST_DONE;
                        valid_o <= 1'b1;
                    end
                default:                            // ST_DONE
                    if (padv_i)
                    begin
                        state   <= exp_pkg::ST_IDLE;
                        valid_o <= 1'b0;
                    end
            endcase
        end
    end

    // operand capture and output register
    always_ff @(posedge clk)
    begin
        if (accept)
            operand_q <= data_i;
        if ((state == exp_pkg::ST_CHECK) && check.is_special)
            data_o <= check.special_result;
        else if ((state == exp_pkg::ST_WAIT) && result_valid_i)
            data_o <= result_i;
    end

    a_valid_done: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> (state == exp_pkg::ST_DONE));

    a_hold: assert property (@(posedge clk) disable iff (rst)
        valid_o && !padv_i |=> valid_o && $stable(data_o));

    a_result_in_wait: assert property (@(posedge clk) disable iff (rst)
        result_valid_i |-> (state == exp_pkg::ST_WAIT));

    // classify decision shows up on the output one cycle later
    a_neg_huge_zero: assert property (@(posedge clk) disable iff (rst)
        (state == exp_pkg::ST_CHECK) && check.is_clamp_neg_huge |=> data_o == `EXP_ZERO);

endmodule

//--- rtl/exp_if.sv
`timescale 1ns/1ps

// operand out to the classifier, direct result back
interface exp_check_if;

    exp_pkg::bf16_t operand;
    logic           is_special;
    exp_pkg::bf16_t special_result;
    logic           is_clamp_neg_huge;  // large negative input, result already zero

    modport ctrl
    (
        output operand,
        input  is_special,
        input  special_result,
        input  is_clamp_neg_huge
    );

    modport classify
    (
        input  operand,
        output is_special,
        output special_result,
        output is_clamp_neg_huge
    );

endinterface

// reduced operand, power and fraction index, valid together
interface exp_reduce_if;

    logic                 valid;
    exp_pkg::pow_int_t    pow_int;
    exp_pkg::frac_idx_t   frac_idx;
    logic                 zero_frac;

    modport reduce   (output valid, output pow_int, output frac_idx, output zero_frac);
    modport assemble (input  valid, input  pow_int, input  frac_idx, input  zero_frac);

endinterface

//--- rtl/exp_pkg.sv
package exp_pkg;

    // bfloat16 word and its fields
    typedef logic [15:0] bf16_t;
    typedef logic [7:0]  exp_field_t;   // biased exponent
    typedef logic [6:0]  man_field_t;   // stored fraction, hidden bit dropped

    // operand magnitude, 7 integer and 16 fraction bits
    typedef logic [22:0] fix_mag_t;

    // integer power n of the result, -135 .. 134
    typedef logic signed [8:0] pow_int_t;

    // index k of 2^(k/64)
    typedef logic [5:0] frac_idx_t;

    // sequencer states
    typedef enum logic [1:0]
    {
        ST_IDLE  = 2'd0,
        ST_CHECK = 2'd1,    // operand captured, classify result sampled
        ST_WAIT  = 2'd2,    // computed path in flight
        ST_DONE  = 2'd3     // result held until padv
    } exp_state_t;

endpackage

//--- rtl/exp_range_reduce.sv
`timescale 1ns/1ps
`include "exp_cfg.svh"

module exp_range_reduce
(
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  exp_pkg::bf16_t      operand_i,
    exp_reduce_if.reduce        red
);

    logic                   op_sign;
    exp_pkg::exp_field_t    op_exp;
    logic [7:0]             sig;        // significand with hidden bit
    logic [3:0]             shamt;
    exp_pkg::fix_mag_t      fix_mag;
    logic [$bits(exp_pkg::fix_mag_t)+15:0] prod;
    logic [13:0]            scaled;     // |x|*log2(e), 6 fraction bits
    logic [7:0]             t_int;
    exp_pkg::frac_idx_t     t_frac;
    exp_pkg::pow_int_t      pow_d;
    exp_pkg::frac_idx_t     k_d;

    assign op_sign = operand_i[15];
    assign op_exp  = operand_i[14:7];
    assign sig     = {1'b1, operand_i[6:0]};

    // computed path only sees exponents 118 .. 133
    assign shamt   = 4'(op_exp - exp_pkg::exp_field_t'(`EXP_FIX_BASE_EXP));
    assign fix_mag = exp_pkg::fix_mag_t'(sig) << shamt;
    assign prod    = fix_mag * 16'(`EXP_LOG2E_Q15);
    assign scaled  = prod[$high(prod):25];  // drop 25 of the 31 fraction bits
    assign t_int   = scaled[13:`EXP_FRAC_BITS];
    assign t_frac  = scaled[`EXP_FRAC_BITS-1:0];

    ////////////////////////////////////////////////////////////
    // split into n and k, floor for negative operands
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        if (op_sign)
        begin
            pow_d = exp_pkg::pow_int_t'(-$signed({1'b0, t_int}));
            k_d   = -t_frac;                    // 64 - k, stays 0 for k == 0
            if (t_frac != '0)
                pow_d = pow_d - 9'sd1;
        end
        else
        begin
            pow_d = exp_pkg::pow_int_t'({1'b0, t_int});
            k_d   = t_frac;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            red.valid <= 1'b0;
        else
            red.valid <= start_i;
    end

    always_ff @(posedge clk)
    begin
        if (start_i)
        begin
            red.pow_int   <= pow_d;
            red.frac_idx  <= k_d;
            red.zero_frac <= (k_d == '0);
        end
    end

    a_pow_range: assert property (@(posedge clk) disable iff (rst)
        red.valid |-> (red.pow_int >= -9'sd135) && (red.pow_int <= 9'sd134));

endmodule

//--- rtl/exp_top.sv
`timescale 1ns/1ps

module exp_top
(
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_i,
    input  exp_pkg::bf16_t  data_i,
    input  logic            padv_i,
    output logic            ready_o,
    output logic            valid_o,
    output exp_pkg::bf16_t  data_o
);

    exp_check_if    check_if ();
    exp_reduce_if   red_if ();

    logic           start;
    exp_pkg::bf16_t operand;
    exp_pkg::bf16_t result;
    logic           result_valid;

    exp_ctrl u_ctrl
    (
        .clk            (clk),
        .rst            (rst),
        .valid_i        (valid_i),
        .data_i         (data_i),
        .padv_i         (padv_i),
        .ready_o        (ready_o),
        .valid_o        (valid_o),
        .data_o         (data_o),
        .check          (check_if.ctrl),
        .start_o        (start),
        .operand_o      (operand),
        .result_i       (result),
        .result_valid_i (result_valid)
    );

    exp_classify u_classify (.check (check_if.classify));

    exp_range_reduce u_range_reduce
    (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start),
        .operand_i  (operand),
        .red        (red_if.reduce)
    );

    exp_assemble u_assemble
    (
        .clk            (clk),
        .rst            (rst),
        .red            (red_if.assemble),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the exp_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f exp_top.f --top-module exp_tb \
    -Mdir obj_dir -o exp_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/exp_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -eq 0 ] && grep -q "All tests passed" "$LOG"; then
    echo "simulation PASSED"
    exit 0
fi

echo "simulation FAILED"
exit 1

//--- tb/exp_tb.sv
`timescale 1ns/1ps
`include "exp_cfg.svh"

module exp_tb;

    localparam int NUM_OPS    = 2000;
    localparam int MAX_CYCLES = NUM_OPS * 10 + 100;    // worst case 10 cycles per operation

    logic           clk;
    logic           rst;
    logic           valid_i;
    exp_pkg::bf16_t data_i;
    logic           padv_i;
    logic           ready_o;
    logic           valid_o;
    exp_pkg::bf16_t data_o;

    int             m_tab [64];     // 2^(k/64) mantissas
    exp_pkg::bf16_t cur_op;         // operand in flight, for error lines
    int             cycle_cnt = 0;

    exp_top DUT
    (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .data_i  (data_i),
        .padv_i  (padv_i),
        .ready_o (ready_o),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("[ERROR] t=%0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_result(input exp_pkg::bf16_t expected, input exp_pkg::bf16_t actual);
        if (actual !== expected)
            stop_on_error($sformatf("operand %h: expected result %h, got %h",
                                    cur_op, expected, actual));
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual != expected)
            stop_on_error($sformatf("operand %h: expected latency %0d, got %0d",
                                    cur_op, expected, actual));
    endtask

    task automatic check_flag(input logic expected, input logic actual, input string name);
        if (actual !== expected)
            stop_on_error($sformatf("operand %h: %s expected %b, got %b",
                                    cur_op, name, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    task automatic build_table();
        for (int k = 0; k < 64; k++)
            m_tab[k] = $rtoi($floor(128.0 * $pow(2.0, k / 64.0) + 0.5)) - 128;
    endtask

    function automatic exp_pkg::bf16_t model_exp(input exp_pkg::bf16_t x, output int lat);
        logic           s;
        int             e;
        int             man;
        int             mag;
        longint         t;
        int             n;
        int             k;
        int             b;
        exp_pkg::bf16_t res;
        s   = x[15];
        e   = int'(x[14:7]);
        man = int'(x[6:0]);
        mag = int'(x[14:0]);
        lat = 2;
        if (e == 255 && man != 0)
            res = `EXP_QNAN;
        else if (e == 255)
            res = s ? `EXP_ZERO : `EXP_PINF;
        else if (e == 0)
            res = `EXP_ONE;                             // zero and denormals
        else if (!s && mag < int'(`EXP_MIN_POS))
            res = `EXP_ONE;
        else if (!s && mag > int'(`EXP_MAX_POS))
            res = `EXP_PINF;
        else if (s && mag < int'(`EXP_MIN_NEG_MAG))
            res = `EXP_ONE;
        else if (s && mag > int'(`EXP_MAX_NEG_MAG))
            res = `EXP_ZERO;
        else
        begin
            lat = 4;
            t = ((longint'(128 + man) << (e - `EXP_FIX_BASE_EXP)) * `EXP_LOG2E_Q15) >> 25;
            n = int'(t >> 6);
            k = int'(t & 63);
            if (s)
            begin
                n = -n;
                if (k != 0)
                begin
                    n = n - 1;
                    k = 64 - k;
                end
            end
            b = `EXP_BIAS + n;
            if (b >= 255)
                res = `EXP_PINF;
            else if (b <= 0)
                res = `EXP_ZERO;
            else
                res = {1'b0, 8'(b), 7'(m_tab[k])};
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    function automatic exp_pkg::bf16_t gen_operand();
        int unsigned    sel;
        int unsigned    pick;
        int             off;
        logic           sgn;
        logic [15:0]    th;
        exp_pkg::bf16_t w;
        sel  = $urandom_range(3, 0);
        pick = $urandom_range(3, 0);
        sgn  = 1'($urandom);
        case (sel)
            0:
            begin
                case (pick)
                    0:       w = {sgn, 8'hFF, 7'($urandom_range(127, 1))};   // nan
                    1:       w = {sgn, 8'hFF, 7'd0};
                    2:       w = {sgn, 15'd0};
                    default: w = {sgn, 8'h00, 7'($urandom_range(127, 1))};   // denormal
                endcase
            end
            1:
            begin
                // one below, on, or one above a threshold
                off = int'($urandom_range(2, 0)) - 1;
                case (pick)
                    0:       th = `EXP_MIN_POS;
                    1:       th = `EXP_MAX_POS;
                    2:       th = `EXP_MIN_NEG_MAG;
                    default: th = `EXP_MAX_NEG_MAG;
                endcase
                w = {(pick >= 2), 15'(int'(th) + off)};
            end
            2:       w = {sgn, 8'(`EXP_FIX_BASE_EXP + $urandom_range(15, 0)), 7'($urandom)};
            default: w = 16'($urandom);
        endcase
        return w;
    endfunction

    task automatic run_op(input exp_pkg::bf16_t x);
        exp_pkg::bf16_t expected;
        exp_pkg::bf16_t held;
        int             exp_lat;
        int             lat;
        int             hold_cycles;
        expected = model_exp(x, exp_lat);
        @(posedge clk);
        cur_op  = x;
        valid_i <= 1'b1;
        data_i  <= x;
        @(negedge clk);
        check_flag(1'b1, ready_o, "ready_o before accept");
        @(posedge clk);                 // accepting edge
        valid_i <= 1'b0;
        data_i  <= 16'($urandom);       // must not be captured
        lat = 1;
        @(negedge clk);
        while (!valid_o)
        begin
            check_flag(1'b0, ready_o, "ready_o while busy");
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        check_flag(1'b0, ready_o, "ready_o while result held");
        check_latency(exp_lat, lat);
        check_result(expected, data_o);
        held        = data_o;
        hold_cycles = $urandom_range(3, 0);
        repeat (hold_cycles)
        begin
            @(posedge clk);
            @(negedge clk);
            check_flag(1'b1, valid_o, "valid_o during hold");
            check_flag(1'b0, ready_o, "ready_o during hold");
            check_result(held, data_o);
        end
        @(posedge clk);
        padv_i <= 1'b1;
        @(posedge clk);                 // padv sampled here
        padv_i <= 1'b0;
        @(negedge clk);
        check_flag(1'b0, valid_o, "valid_o after padv");
        check_flag(1'b1, ready_o, "ready_o after padv");
    endtask

    initial
    begin
        void'($urandom(32'h4458));
        build_table();
        rst     = 1'b1;
        valid_i = 1'b0;
        data_i  = '0;
        padv_i  = 1'b0;
        cur_op  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(1'b0, valid_o, "valid_o after reset");
        check_flag(1'b1, ready_o, "ready_o after reset");
        for (int i = 0; i < NUM_OPS; i++)
            run_op(gen_operand());
        $display("All tests passed");
        $finish;
    end

endmodule
